// File: hw/ccu_pkg.sv
////////////////////////////////////////////////////////////
// Shared widths and types for the victim queue
// Line size and memory beat width are fixed here
////////////////////////////////////////////////////////////

package ccu_pkg;

    // Byte address and cache line geometry
    localparam int ADDR_WIDTH     = 32;
    localparam int LINE_BYTES     = 32;
    localparam int OFFSET_WIDTH   = $clog2(LINE_BYTES);
    localparam int LINE_WIDTH     = LINE_BYTES * 8;

    // Memory write beats
    localparam int MEM_DATA_WIDTH = 64;
    localparam int BEATS_PER_LINE = LINE_WIDTH / MEM_DATA_WIDTH;
    localparam int BEAT_WIDTH     = $clog2(BEATS_PER_LINE);

    // Line address drops the byte offset within the line
    typedef logic [ADDR_WIDTH-OFFSET_WIDTH-1:0] line_addr_t;
    typedef logic [LINE_WIDTH-1:0]              line_data_t;

    typedef logic [ADDR_WIDTH-1:0]              mem_addr_t;
    typedef logic [MEM_DATA_WIDTH-1:0]          mem_data_t;

    // Writeback FSM states
    typedef enum logic [1:0] {
        WB_IDLE = 2'd0,
        WB_SEND = 2'd1,
        WB_WAIT = 2'd2
    } wb_state_t;

endpackage

// File: hw/ccu_vq_entry.sv
////////////////////////////////////////////////////////////
// Single victim queue entry
// Allocation and done must not hit the same entry in one cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ccu_vq_entry (
    input  logic                clk,
    input  logic                i_arst_n,

    // Allocation from the eviction strobe
    input  logic                i_alloc_en,
    input  ccu_pkg::line_addr_t i_alloc_addr,
    input  ccu_pkg::line_data_t i_alloc_data,

    // Writeback finished with this entry
    input  logic                i_ccu_done,

    // Lookup compare
    input  ccu_pkg::line_addr_t i_lookup_addr,
    output logic                o_lookup_hit,

    output logic                o_vq_entry_valid,
    output ccu_pkg::line_addr_t o_vq_entry_addr,
    output ccu_pkg::line_data_t o_vq_entry_data
);
    import ccu_pkg::*;

    typedef enum logic {
        VQ_ENTRY_INVALID = 1'b0,
        VQ_ENTRY_VALID   = 1'b1
    } vq_entry_state_t;

    vq_entry_state_t state_r;
    vq_entry_state_t state_next;
    line_addr_t      addr_r;
    line_data_t      data_r;

    always_comb begin
        state_next = state_r;
        case (state_r)
            VQ_ENTRY_INVALID: if (i_alloc_en) state_next = VQ_ENTRY_VALID;
            VQ_ENTRY_VALID:   if (i_ccu_done) state_next = VQ_ENTRY_INVALID;
            default:          state_next = VQ_ENTRY_INVALID;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_r <= VQ_ENTRY_INVALID;
        end else begin
            state_r <= state_next;
        end
    end

    // Payload only changes on allocation
    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            addr_r <= i_alloc_addr;
            data_r <= i_alloc_data;
        end
    end

    assign o_vq_entry_valid = (state_r == VQ_ENTRY_VALID);
    assign o_vq_entry_addr  = addr_r;
    assign o_vq_entry_data  = data_r;
    assign o_lookup_hit     = o_vq_entry_valid && (addr_r == i_lookup_addr);

endmodule

// File: hw/ccu_victim_queue.sv
////////////////////////////////////////////////////////////
// Circular victim queue of OPTN_VQ_DEPTH entries
// Depth must be a power of two, at least 2
// No eviction may arrive while o_full is high
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ccu_victim_queue #(
    parameter int OPTN_VQ_DEPTH = 4
)(
    input  logic                clk,
    input  logic                i_arst_n,

    // Eviction from the data cache
    input  logic                i_evict_en,
    input  ccu_pkg::line_addr_t i_evict_addr,
    input  ccu_pkg::line_data_t i_evict_data,
    output logic                o_full,

    // Load/store lookup
    input  ccu_pkg::line_addr_t i_lookup_addr,
    output logic                o_lookup_hit,
    output ccu_pkg::line_data_t o_lookup_data,

    // Oldest entry towards writeback
    output logic                o_head_valid,
    output ccu_pkg::line_addr_t o_head_addr,
    output ccu_pkg::line_data_t o_head_data,
    input  logic                i_head_done
);
    import ccu_pkg::*;

    localparam int PTR_WIDTH = $clog2(OPTN_VQ_DEPTH);
    localparam int CNT_WIDTH = PTR_WIDTH + 1;

    logic [OPTN_VQ_DEPTH-1:0] entry_alloc;
    logic [OPTN_VQ_DEPTH-1:0] entry_done;
    logic [OPTN_VQ_DEPTH-1:0] entry_valid;
    logic [OPTN_VQ_DEPTH-1:0] entry_hit;
    line_addr_t               entry_addr [OPTN_VQ_DEPTH];
    line_data_t               entry_data [OPTN_VQ_DEPTH];

    logic [PTR_WIDTH-1:0]     tail_ptr_r;
    logic [PTR_WIDTH-1:0]     head_ptr_r;
    logic [CNT_WIDTH-1:0]     count_r;
    logic [PTR_WIDTH-1:0]     age_idx;

    // Route the strobes to the tail and head entries
    always_comb begin
        for (int i = 0; i < OPTN_VQ_DEPTH; i++) begin
            entry_alloc[i] = i_evict_en && (tail_ptr_r == PTR_WIDTH'(i));
            entry_done[i]  = i_head_done && (head_ptr_r == PTR_WIDTH'(i));
        end
    end

    for (genvar i = 0; i < OPTN_VQ_DEPTH; i++) begin : g_entry
        ccu_vq_entry ccu_vq_entry_i (
            .clk              (clk),
            .i_arst_n         (i_arst_n),
            .i_alloc_en       (entry_alloc[i]),
            .i_alloc_addr     (i_evict_addr),
            .i_alloc_data     (i_evict_data),
            .i_ccu_done       (entry_done[i]),
            .i_lookup_addr    (i_lookup_addr),
            .o_lookup_hit     (entry_hit[i]),
            .o_vq_entry_valid (entry_valid[i]),
            .o_vq_entry_addr  (entry_addr[i]),
            .o_vq_entry_data  (entry_data[i])
        );
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            tail_ptr_r <= '0;
            head_ptr_r <= '0;
            count_r    <= '0;
        end else begin
            if (i_evict_en) begin
                tail_ptr_r <= tail_ptr_r + 1'b1;
            end
            if (i_head_done) begin
                head_ptr_r <= head_ptr_r + 1'b1;
            end
            case ({i_evict_en, i_head_done})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
        end
    end

    // The line in writeback still holds its entry until done
    assign o_full = (count_r == CNT_WIDTH'(OPTN_VQ_DEPTH));

    // Walk from oldest to youngest so the newest copy of a line wins
    always_comb begin
        o_lookup_data = '0;
        age_idx       = head_ptr_r;
        for (int i = 0; i < OPTN_VQ_DEPTH; i++) begin
            age_idx = head_ptr_r + PTR_WIDTH'(i);
            if (entry_hit[age_idx]) begin
                o_lookup_data = entry_data[age_idx];
            end
        end
    end

    assign o_lookup_hit = |entry_hit;

    assign o_head_valid = entry_valid[head_ptr_r];
    assign o_head_addr  = entry_addr[head_ptr_r];
    assign o_head_data  = entry_data[head_ptr_r];

endmodule

// File: hw/ccu_writeback.sv
////////////////////////////////////////////////////////////
// Sends the head line to memory as consecutive beats
// Memory must pulse done no earlier than after the last beat
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ccu_writeback (
    input  logic                clk,
    input  logic                i_arst_n,

    // Head entry of the victim queue
    input  logic                i_head_valid,
    input  ccu_pkg::line_addr_t i_head_addr,
    input  ccu_pkg::line_data_t i_head_data,
    output logic                o_head_done,

    // Memory write port
    output logic                o_mem_wr_en,
    output ccu_pkg::mem_addr_t  o_mem_addr,
    output ccu_pkg::mem_data_t  o_mem_data,
    input  logic                i_mem_done
);
    import ccu_pkg::*;

    localparam int BYTE_SEL_WIDTH = OFFSET_WIDTH - BEAT_WIDTH;

    wb_state_t             state_r;
    wb_state_t             state_next;
    logic [BEAT_WIDTH-1:0] beat_r;
    logic                  last_beat;
    logic                  start;
    line_addr_t            line_addr_r;
    line_data_t            line_data_r;

    assign last_beat = (beat_r == BEAT_WIDTH'(BEATS_PER_LINE - 1));
    assign start     = (state_r == WB_IDLE) && i_head_valid;

    always_comb begin
        state_next = state_r;
        case (state_r)
            WB_IDLE: if (i_head_valid) state_next = WB_SEND;
            WB_SEND: if (last_beat)    state_next = WB_WAIT;
            WB_WAIT: if (i_mem_done)   state_next = WB_IDLE;
            default: state_next = WB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_r <= WB_IDLE;
            beat_r  <= '0;
        end else begin
            state_r <= state_next;
            // Counter wraps back to zero after the last beat
            if (state_r == WB_SEND) begin
                beat_r <= beat_r + 1'b1;
            end
        end
    end

    // Copy of the head line, taken when a writeback starts
    always_ff @(posedge clk) begin
        if (start) begin
            line_addr_r <= i_head_addr;
            line_data_r <= i_head_data;
        end
    end

    assign o_mem_wr_en = (state_r == WB_SEND);
    assign o_mem_addr  = {line_addr_r, beat_r, {BYTE_SEL_WIDTH{1'b0}}};
    // Beat 0 carries the low bits of the line
    assign o_mem_data  = line_data_r[beat_r*MEM_DATA_WIDTH +: MEM_DATA_WIDTH];

    // Done frees the queue entry in the same cycle
    assign o_head_done = (state_r == WB_WAIT) && i_mem_done;

endmodule

// File: hw/ccu_vq_top.sv
////////////////////////////////////////////////////////////
// Victim queue with its writeback stage
// Evictions are illegal while o_full is high
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ccu_vq_top #(
    parameter int OPTN_VQ_DEPTH = 4
)(
    input  logic                clk,
    input  logic                i_arst_n,

    // Eviction from the data cache
    input  logic                i_evict_en,
    input  ccu_pkg::line_addr_t i_evict_addr,
    input  ccu_pkg::line_data_t i_evict_data,
    output logic                o_full,

    // Lookup, answered in the same cycle
    input  ccu_pkg::line_addr_t i_lookup_addr,
    output logic                o_lookup_hit,
    output ccu_pkg::line_data_t o_lookup_data,

    // Memory write port
    output logic                o_mem_wr_en,
    output ccu_pkg::mem_addr_t  o_mem_addr,
    output ccu_pkg::mem_data_t  o_mem_data,
    input  logic                i_mem_done
);
    import ccu_pkg::*;

    logic       head_valid;
    line_addr_t head_addr;
    line_data_t head_data;
    logic       head_done;

    ccu_victim_queue #(
        .OPTN_VQ_DEPTH (OPTN_VQ_DEPTH)
    ) ccu_victim_queue_i (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_evict_en    (i_evict_en),
        .i_evict_addr  (i_evict_addr),
        .i_evict_data  (i_evict_data),
        .o_full        (o_full),
        .i_lookup_addr (i_lookup_addr),
        .o_lookup_hit  (o_lookup_hit),
        .o_lookup_data (o_lookup_data),
        .o_head_valid  (head_valid),
        .o_head_addr   (head_addr),
        .o_head_data   (head_data),
        .i_head_done   (head_done)
    );

    ccu_writeback ccu_writeback_i (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_head_valid (head_valid),
        .i_head_addr  (head_addr),
        .i_head_data  (head_data),
        .o_head_done  (head_done),
        .o_mem_wr_en  (o_mem_wr_en),
        .o_mem_addr   (o_mem_addr),
        .o_mem_data   (o_mem_data),
        .i_mem_done   (i_mem_done)
    );

endmodule

// File: verif/ccu_vq_properties.sv
////////////////////////////////////////////////////////////
// Protocol checks bound into ccu_vq_top
// Assumes memory pulses done only after the last beat
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ccu_vq_properties (
    input logic clk,
    input logic i_arst_n,
    input logic i_evict_en,
    input logic o_full,
    input logic o_mem_wr_en,
    input logic i_mem_done
);
    int fail_count = 0;

    // Cache must hold off evictions while the queue is full
    evict_not_full: assert property (
        @(posedge clk) disable iff (!i_arst_n) i_evict_en |-> !o_full
    ) else begin
        $error("eviction strobe while o_full is high");
        fail_count++;
    end

    // Done belongs to the wait phase, never to a beat
    no_beat_on_done: assert property (
        @(posedge clk) disable iff (!i_arst_n) !(o_mem_wr_en && i_mem_done)
    ) else begin
        $error("write beat in the cycle of i_mem_done");
        fail_count++;
    end

    // One line is exactly four back to back beats
    beat_run_of_four: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        $rose(o_mem_wr_en) |-> o_mem_wr_en [*4] ##1 !o_mem_wr_en
    ) else begin
        $error("o_mem_wr_en run is not four beats long");
        fail_count++;
    end

    reset_not_full: assert property (
        @(posedge clk) $rose(i_arst_n) |-> !o_full
    ) else begin
        $error("o_full high after reset");
        fail_count++;
    end

endmodule

bind ccu_vq_top ccu_vq_properties ccu_vq_properties_i (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_evict_en  (i_evict_en),
    .o_full      (o_full),
    .o_mem_wr_en (o_mem_wr_en),
    .i_mem_done  (i_mem_done)
);

// File: verif/ccu_vq_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the victim queue and its writeback stage
// Memory responder pulses done only after the fourth beat
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ccu_vq_tb;
    import ccu_pkg::*;

    localparam int VQ_DEPTH     = 4;
    localparam int CLK_PERIOD   = 4;
    localparam int N_RANDOM     = 40;
    localparam int TOTAL_EVICTS = 1 + VQ_DEPTH + N_RANDOM;
    localparam int BEAT_BYTES   = MEM_DATA_WIDTH / 8;

    logic       clk;
    logic       i_arst_n;
    logic       i_evict_en;
    line_addr_t i_evict_addr;
    line_data_t i_evict_data;
    logic       o_full;
    line_addr_t i_lookup_addr;
    logic       o_lookup_hit;
    line_data_t o_lookup_data;
    logic       o_mem_wr_en;
    mem_addr_t  o_mem_addr;
    mem_data_t  o_mem_data;
    logic       i_mem_done;

    // Every line evicted so far, oldest first
    line_addr_t model_addr[$];
    line_data_t model_data[$];
    int         freed_cnt = 0;
    int         lines_written = 0;
    int         beat_idx = 0;
    int         done_delays[$];
    logic       hold_done = 1'b0;

    integer     seed = 2;
    int         errors = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    int         test_start_errors = 0;

    ccu_vq_top #(
        .OPTN_VQ_DEPTH (VQ_DEPTH)
    ) ccu_vq_top_i (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_evict_en    (i_evict_en),
        .i_evict_addr  (i_evict_addr),
        .i_evict_data  (i_evict_data),
        .o_full        (o_full),
        .i_lookup_addr (i_lookup_addr),
        .o_lookup_hit  (o_lookup_hit),
        .o_lookup_data (o_lookup_data),
        .o_mem_wr_en   (o_mem_wr_en),
        .o_mem_addr    (o_mem_addr),
        .o_mem_data    (o_mem_data),
        .i_mem_done    (i_mem_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic int total_errors();
        return errors + ccu_vq_top_i.ccu_vq_properties_i.fail_count;
    endfunction

    // Newest parked copy of a line answers the lookup
    function automatic void expected_lookup(input line_addr_t addr, output logic hit,
                                            output line_data_t data);
        hit  = 1'b0;
        data = '0;
        for (int i = freed_cnt; i < model_addr.size(); i++) begin
            if (model_addr[i] == addr) begin
                hit  = 1'b1;
                data = model_data[i];
            end
        end
    endfunction

    function automatic mem_addr_t expected_beat_addr(input line_addr_t addr, input int beat);
        return {addr, {OFFSET_WIDTH{1'b0}}} + mem_addr_t'(beat * BEAT_BYTES);
    endfunction

    function automatic mem_data_t expected_beat_data(input line_data_t data, input int beat);
        return mem_data_t'(data >> (beat * MEM_DATA_WIDTH));
    endfunction

    function automatic line_addr_t rand_addr();
        return line_addr_t'($random(seed));
    endfunction

    function automatic line_data_t rand_line();
        line_data_t d;
        for (int i = 0; i < LINE_WIDTH / 32; i++) begin
            d[i*32 +: 32] = $random(seed);
        end
        return d;
    endfunction

    // Half of the lookups target a parked line when there is one
    function automatic line_addr_t pick_lookup_addr();
        int parked;
        parked = model_addr.size() - freed_cnt;
        if (parked > 0 && $random(seed) % 2 == 0) begin
            return model_addr[freed_cnt + ($unsigned($random(seed)) % parked)];
        end
        return rand_addr();
    endfunction

    task automatic value_error(input string name, input logic [LINE_WIDTH-1:0] got,
                               input logic [LINE_WIDTH-1:0] exp);
        $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (total_errors() == test_start_errors) begin
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAILED, %0d errors", name, total_errors() - test_start_errors);
        end
        test_start_errors = total_errors();
    endtask

    // Called right after a falling edge, returns at the next one
    task automatic evict_line(input line_addr_t addr, input line_data_t data, input int delay);
        while (o_full) begin
            @(negedge clk);
        end
        i_evict_en   = 1'b1;
        i_evict_addr = addr;
        i_evict_data = data;
        done_delays.push_back(delay);
        @(negedge clk);
        i_evict_en = 1'b0;
    endtask

    task automatic wait_drained(input int max_cycles);
        int n;
        n = 0;
        while ((freed_cnt < model_addr.size() || lines_written < model_addr.size())
               && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (freed_cnt < model_addr.size() || lines_written < model_addr.size()) begin
            $display("Queue did not drain within %0d cycles", max_cycles);
            errors++;
        end
    endtask

    // Reference model follows the strobes at each rising edge
    initial begin : model_update
        forever begin
            @(posedge clk);
            if (i_arst_n) begin
                if (i_evict_en) begin
                    model_addr.push_back(i_evict_addr);
                    model_data.push_back(i_evict_data);
                end
                if (i_mem_done && freed_cnt < lines_written) begin
                    freed_cnt++;
                end
            end
        end
    end

    initial begin : mem_responder
        int beats;
        int delay;
        beats = 0;
        forever begin
            @(negedge clk);
            i_mem_done = 1'b0;
            if (o_mem_wr_en === 1'b1) begin
                beats++;
            end
            if (beats == BEATS_PER_LINE) begin
                beats = 0;
                delay = (done_delays.size() > 0) ? done_delays.pop_front() : 0;
                repeat (delay + 1) @(negedge clk);
                while (hold_done) begin
                    @(negedge clk);
                end
                i_mem_done = 1'b1;
            end
        end
    end

    // Sampled one ns before the rising edge, when all outputs are settled
    initial begin : compare
        logic       exp_hit;
        line_data_t exp_data;
        logic       exp_full;
        @(posedge i_arst_n);
        forever begin
            @(negedge clk);
            #1;
            expected_lookup(i_lookup_addr, exp_hit, exp_data);
            exp_full = ((model_addr.size() - freed_cnt) == VQ_DEPTH);
            if (o_lookup_hit !== exp_hit) begin
                value_error("o_lookup_hit", o_lookup_hit, exp_hit);
            end
            if (exp_hit && o_lookup_data !== exp_data) begin
                value_error("o_lookup_data", o_lookup_data, exp_data);
            end
            if (o_full !== exp_full) begin
                value_error("o_full", o_full, exp_full);
            end
            if (o_mem_wr_en === 1'b1) begin
                if (lines_written >= model_addr.size()) begin
                    $display("Write beat at %0t ns with no line waiting", $time);
                    errors++;
                end else begin
                    if (o_mem_addr !== expected_beat_addr(model_addr[lines_written], beat_idx)) begin
                        value_error("o_mem_addr", o_mem_addr,
                                    expected_beat_addr(model_addr[lines_written], beat_idx));
                    end
                    if (o_mem_data !== expected_beat_data(model_data[lines_written], beat_idx)) begin
                        value_error("o_mem_data", o_mem_data,
                                    expected_beat_data(model_data[lines_written], beat_idx));
                    end
                    beat_idx++;
                    if (beat_idx == BEATS_PER_LINE) begin
                        beat_idx = 0;
                        lines_written++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(TOTAL_EVICTS * 200 * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin : stimulus
        line_addr_t a;
        line_data_t d;
        logic       hit;
        int         f0;
        int         gap;
        i_arst_n      = 1'b0;
        i_evict_en    = 1'b0;
        i_evict_addr  = '0;
        i_evict_data  = '0;
        i_lookup_addr = '0;
        i_mem_done    = 1'b0;
        repeat (10) @(negedge clk);
        i_arst_n = 1'b1;
        @(negedge clk);

        // Idle outputs and misses right after reset
        for (int n = 0; n < 8; n++) begin
            i_lookup_addr = rand_addr();
            #1;
            if (o_full !== 1'b0) value_error("o_full", o_full, 1'b0);
            if (o_lookup_hit !== 1'b0) value_error("o_lookup_hit", o_lookup_hit, 1'b0);
            if (o_mem_wr_en !== 1'b0) value_error("o_mem_wr_en", o_mem_wr_en, 1'b0);
            @(negedge clk);
        end
        end_test("reset state");

        a = rand_addr();
        d = rand_line();
        i_lookup_addr = a;
        evict_line(a, d, 5);
        wait_drained(100);
        repeat (2) @(negedge clk);
        if (lines_written != 1) value_error("lines written", lines_written, 1);
        end_test("single eviction");

        // Withheld done keeps the head in writeback
        hold_done = 1'b1;
        for (int n = 0; n < VQ_DEPTH; n++) begin
            if (o_full) begin
                $display("o_full high with only %0d lines in the queue", n);
                errors++;
            end else begin
                evict_line(rand_addr(), rand_line(), 0);
            end
        end
        if (o_full !== 1'b1) value_error("o_full", o_full, 1'b1);
        end_test("fill to full");

        for (int i = freed_cnt; i < model_addr.size(); i++) begin
            i_lookup_addr = model_addr[i];
            @(negedge clk);
        end
        for (int n = 0; n < 8; n++) begin
            do begin
                a = rand_addr();
                expected_lookup(a, hit, d);
            end while (hit);
            i_lookup_addr = a;
            @(negedge clk);
        end
        end_test("lookups while full");

        f0 = freed_cnt;
        @(posedge clk);
        hold_done = 1'b0;
        @(negedge clk);
        while (freed_cnt == f0) begin
            @(negedge clk);
        end
        if (o_full !== 1'b0) value_error("o_full", o_full, 1'b0);
        wait_drained(200);
        if (lines_written != model_addr.size()) begin
            value_error("lines written", lines_written, model_addr.size());
        end
        end_test("drain in order");

        for (int n = 0; n < N_RANDOM; n++) begin
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) begin
                i_lookup_addr = pick_lookup_addr();
                @(negedge clk);
            end
            i_lookup_addr = pick_lookup_addr();
            evict_line(rand_addr(), rand_line(), $unsigned($random(seed)) % 21);
        end
        wait_drained(N_RANDOM * 40);
        if (lines_written != model_addr.size()) begin
            value_error("lines written", lines_written, model_addr.size());
        end
        end_test("random traffic");

        repeat (5) @(negedge clk);
        $display("Summary: %0d tests, %0d failed, %0d errors, %0d of %0d lines written",
                 tests_run, tests_failed, total_errors(), lines_written, model_addr.size());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: project.f
hw/ccu_pkg.sv
hw/ccu_vq_entry.sv
hw/ccu_victim_queue.sv
hw/ccu_writeback.sv
hw/ccu_vq_top.sv
verif/ccu_vq_properties.sv
verif/ccu_vq_tb.sv
